/* build.f */
i2c_pkg.sv
i2c_master.sv
i2c_slave.sv
i2c_slave_regs.sv
i2c_system.sv
tb_i2c_system.sv

/* tb_i2c_system.sv */
`timescale 1ns/1ps

module tb_i2c_system;

    localparam int                 CLK_DIV    = 4;
    localparam i2c_pkg::dev_addr_t SLAVE_ADDR = 7'h55;
    localparam int                 NUM_REGS   = i2c_pkg::NUM_REGS;

    // Every transaction below counted as one command per START, byte and STOP
    localparam int NUM_CMDS   = 31;
    localparam int TIMEOUT_NS = NUM_CMDS * 12 * 4 * CLK_DIV * 10 + 2000;

    logic           clk = 1'b0;
    logic           reset;
    logic           start;
    logic           stop;
    logic           i2c_en;
    i2c_pkg::byte_t tx_data;
    logic           ready;
    logic           tx_done;
    logic           rx_done;
    logic           nack;
    i2c_pkg::byte_t rx_data;
    i2c_pkg::byte_t led;

    // Reference model of the slave register file
    i2c_pkg::byte_t    model_regs [NUM_REGS];
    i2c_pkg::reg_ptr_t model_ptr;

    logic           exp_nack;
    i2c_pkg::byte_t exp_rx;
    i2c_pkg::byte_t exp_led;
    logic           led_check;
    logic           status_check;
    integer         seed;
    int             errors;
    int             byte_cmds;
    int             done_pulses;

    i2c_system #(
        .CLK_DIV   (CLK_DIV),
        .SLAVE_ADDR(SLAVE_ADDR)
    ) u_i2c_system (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .stop   (stop),
        .i2c_en (i2c_en),
        .tx_data(tx_data),
        .ready  (ready),
        .tx_done(tx_done),
        .rx_done(rx_done),
        .nack   (nack),
        .rx_data(rx_data),
        .led    (led)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (!reset && (tx_done || rx_done)) begin
            done_pulses++;
        end
    end

    a_status_after_reset: assert property (
        @(posedge clk) status_check |-> ({ready, tx_done, rx_done, nack} == 4'b1000)
    ) else begin
        errors++;
        $display("FAIL %0t {ready,tx_done,rx_done,nack} expected 1000 got %b",
                 $time, $sampled({ready, tx_done, rx_done, nack}));
    end

    a_led_value: assert property (
        @(posedge clk) disable iff (reset)
        led_check |-> (led == exp_led)
    ) else begin
        errors++;
        $display("FAIL %0t led expected %h got %h", $time, $sampled(exp_led), $sampled(led));
    end

    a_ack_seen: assert property (
        @(posedge clk) disable iff (reset)
        tx_done |-> (nack == exp_nack)
    ) else begin
        errors++;
        $display("FAIL %0t nack expected %b got %b", $time, $sampled(exp_nack), $sampled(nack));
    end

    a_read_data: assert property (
        @(posedge clk) disable iff (reset)
        rx_done |-> (rx_data == exp_rx)
    ) else begin
        errors++;
        $display("FAIL %0t rx_data expected %h got %h", $time, $sampled(exp_rx), $sampled(rx_data));
    end

    // One command, then a stray i2c_en pulse while the master is busy
    task automatic issue_cmd(input logic s, input logic p, input i2c_pkg::byte_t data);
        begin
            start   <= s;
            stop    <= p;
            tx_data <= data;
            i2c_en  <= 1'b1;
            @(posedge clk);
            tx_data <= ~data;
            @(posedge clk);
            i2c_en <= 1'b0;
            if (s || !p) begin
                byte_cmds++;
            end
            do begin
                @(posedge clk);
            end while (!ready);
        end
    endtask

    task automatic write_txn(input int count);
        i2c_pkg::byte_t data;
        begin
            exp_nack = 1'b0;
            issue_cmd(1'b1, 1'b0, {SLAVE_ADDR, 1'b0});
            model_ptr = '0;
            for (int i = 0; i < count; i++) begin
                data = i2c_pkg::byte_t'($random(seed));
                issue_cmd(1'b0, 1'b0, data);
                model_regs[model_ptr] = data;
                model_ptr = model_ptr + 1'b1;
            end
            issue_cmd(1'b0, 1'b1, 8'h00);
        end
    endtask

    // Reads all registers, the last one answered with NACK
    task automatic read_txn;
        begin
            exp_nack = 1'b0;
            issue_cmd(1'b1, 1'b0, {SLAVE_ADDR, 1'b1});
            model_ptr = '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                exp_rx = model_regs[model_ptr];
                if (i == NUM_REGS - 1) begin
                    issue_cmd(1'b1, 1'b1, 8'h00);
                end else begin
                    issue_cmd(1'b0, 1'b0, 8'h00);
                    model_ptr = model_ptr + 1'b1;
                end
            end
            issue_cmd(1'b0, 1'b1, 8'h00);
        end
    endtask

    task automatic check_led;
        begin
            exp_led = model_regs[0];
            led_check <= 1'b1;
            @(posedge clk);
            led_check <= 1'b0;
        end
    endtask

    initial begin
        reset        = 1'b1;
        start        = 1'b0;
        stop         = 1'b0;
        i2c_en       = 1'b0;
        tx_data      = '0;
        led_check    = 1'b0;
        status_check = 1'b0;
        exp_nack     = 1'b0;
        exp_rx       = '0;
        exp_led      = '0;
        model_ptr    = '0;
        seed         = 82;
        errors       = 0;
        byte_cmds    = 0;
        done_pulses  = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        status_check <= 1'b1;
        check_led();
        status_check <= 1'b0;

        write_txn(4);
        check_led();
        read_txn();

        // Nobody answers at this address and the data byte sent after it must be ignored
        exp_nack = 1'b1;
        issue_cmd(1'b1, 1'b0, {SLAVE_ADDR ^ 7'h2A, 1'b0});
        issue_cmd(1'b0, 1'b0, ~model_regs[0]);
        issue_cmd(1'b0, 1'b1, 8'h00);
        read_txn();

        write_txn(2);
        check_led();
        read_txn();

        repeat (4) @(posedge clk);
        assert (done_pulses == byte_cmds) else begin
            errors++;
            $display("FAIL %0t done pulse count expected %0d got %0d",
                     $time, byte_cmds, done_pulses);
        end

        $display("Summary: %0d errors, %0d byte commands, %0d done pulses",
                 errors, byte_cmds, done_pulses);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the master did not finish all commands within %0d ns", TIMEOUT_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* i2c_system.sv */
`timescale 1ns/1ps

module i2c_system #(
    parameter int                 CLK_DIV    = 4,
    parameter i2c_pkg::dev_addr_t SLAVE_ADDR = 7'h55
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  logic           stop,
    input  logic           i2c_en,
    input  i2c_pkg::byte_t tx_data,
    output logic           ready,
    output logic           tx_done,
    output logic           rx_done,
    output logic           nack,
    output i2c_pkg::byte_t rx_data,
    output i2c_pkg::byte_t led
);

    // Shared SDA line, high unless one side pulls it low
    tri1            sda;
    logic           scl;
    logic           master_pull;
    logic           slave_pull;
    logic           reg_wr;
    logic           reg_rd_next;
    logic           ptr_clear;
    i2c_pkg::byte_t wr_data;
    i2c_pkg::byte_t rd_data;

    assign sda = master_pull ? 1'b0 : 1'bz;
    assign sda = slave_pull ? 1'b0 : 1'bz;

    i2c_master #(
        .CLK_DIV(CLK_DIV)
    ) u_master (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .stop        (stop),
        .i2c_en      (i2c_en),
        .tx_data     (tx_data),
        .sda_in      (sda),
        .ready       (ready),
        .tx_done     (tx_done),
        .rx_done     (rx_done),
        .nack        (nack),
        .rx_data     (rx_data),
        .scl         (scl),
        .sda_pull_low(master_pull)
    );

    i2c_slave #(
        .SLAVE_ADDR(SLAVE_ADDR)
    ) u_slave (
        .clk         (clk),
        .reset       (reset),
        .scl         (scl),
        .sda_in      (sda),
        .rd_data     (rd_data),
        .sda_pull_low(slave_pull),
        .reg_wr      (reg_wr),
        .wr_data     (wr_data),
        .reg_rd_next (reg_rd_next),
        .ptr_clear   (ptr_clear)
    );

    i2c_slave_regs u_regs (
        .clk        (clk),
        .reset      (reset),
        .reg_wr     (reg_wr),
        .wr_data    (wr_data),
        .reg_rd_next(reg_rd_next),
        .ptr_clear  (ptr_clear),
        .rd_data    (rd_data),
        .led        (led)
    );

endmodule

/* i2c_slave_regs.sv */
`timescale 1ns/1ps

module i2c_slave_regs (
    input  logic           clk,
    input  logic           reset,
    input  logic           reg_wr,
    input  i2c_pkg::byte_t wr_data,
    input  logic           reg_rd_next,
    input  logic           ptr_clear,
    output i2c_pkg::byte_t rd_data,
    output i2c_pkg::byte_t led
);

    i2c_pkg::byte_t    regs [i2c_pkg::NUM_REGS];
    i2c_pkg::reg_ptr_t ptr;
    i2c_pkg::reg_ptr_t ptr_next;

    // Pointer wraps at the last register
    assign ptr_next = (ptr == i2c_pkg::reg_ptr_t'(i2c_pkg::NUM_REGS - 1)) ? '0 : ptr + 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
            for (int i = 0; i < i2c_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ptr_clear) begin
            ptr <= '0;
        end else if (reg_wr) begin
            regs[ptr] <= wr_data;
            ptr       <= ptr_next;
        end else if (reg_rd_next) begin
            ptr <= ptr_next;
        end
    end

    assign rd_data = regs[ptr];
    assign led     = regs[0];

    a_wr_rd_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(reg_wr && reg_rd_next)
    );

endmodule

/* i2c_slave.sv */
`timescale 1ns/1ps

module i2c_slave #(
    parameter i2c_pkg::dev_addr_t SLAVE_ADDR = 7'h55
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           scl,
    input  logic           sda_in,
    input  i2c_pkg::byte_t rd_data,
    output logic           sda_pull_low,
    output logic           reg_wr,
    output i2c_pkg::byte_t wr_data,
    output logic           reg_rd_next,
    output logic           ptr_clear
);

    i2c_pkg::slave_state_e state;
    i2c_pkg::byte_t        shift;
    logic [1:0]            scl_sync;
    logic [1:0]            sda_sync;
    logic                  scl_q;
    logic                  sda_q;
    logic                  scl_s;
    logic                  sda_s;
    logic                  scl_rise;
    logic                  scl_fall;
    logic                  start_det;
    logic                  stop_det;
    logic                  load_rd;
    logic [3:0]            bit_cnt;
    logic                  rw;
    logic                  rd_acked;

    // Bus lines are brought into clk with two flops, plus one more for edge detection
    always_ff @(posedge clk) begin
        if (reset) begin
            scl_sync <= 2'b11;
            sda_sync <= 2'b11;
            scl_q    <= 1'b1;
            sda_q    <= 1'b1;
        end else begin
            scl_sync <= {scl_sync[0], scl};
            sda_sync <= {sda_sync[0], sda_in};
            scl_q    <= scl_s;
            sda_q    <= sda_s;
        end
    end

    assign scl_s     = scl_sync[1];
    assign sda_s     = sda_sync[1];
    assign scl_rise  = scl_s & ~scl_q;
    assign scl_fall  = ~scl_s & scl_q;
    assign start_det = scl_s & scl_q & sda_q & ~sda_s;
    assign stop_det  = scl_s & scl_q & ~sda_q & sda_s;

    // The next read byte is fetched when the preceding ACK bit ends
    assign load_rd = scl_fall &&
                     ((state == i2c_pkg::S_ADDR_ACK && rw) ||
                      (state == i2c_pkg::S_RD_ACK && rd_acked));

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= i2c_pkg::S_IDLE;
            bit_cnt      <= 4'd0;
            sda_pull_low <= 1'b0;
            reg_wr       <= 1'b0;
            reg_rd_next  <= 1'b0;
            ptr_clear    <= 1'b0;
            rw           <= 1'b0;
            rd_acked     <= 1'b0;
        end else begin
            reg_wr      <= 1'b0;
            reg_rd_next <= 1'b0;
            ptr_clear   <= 1'b0;
            if (start_det) begin
                state        <= i2c_pkg::S_ADDR;
                bit_cnt      <= 4'd0;
                sda_pull_low <= 1'b0;
                ptr_clear    <= 1'b1;
            end else if (stop_det) begin
                state        <= i2c_pkg::S_IDLE;
                sda_pull_low <= 1'b0;
            end else begin
                case (state)
                    i2c_pkg::S_ADDR, i2c_pkg::S_WR_BYTE: begin
                        if (scl_rise && bit_cnt != 4'd8) begin
                            bit_cnt <= bit_cnt + 4'd1;
                            if (state == i2c_pkg::S_WR_BYTE && bit_cnt == 4'd7) begin
                                reg_wr <= 1'b1;
                            end
                        end else if (scl_fall && bit_cnt == 4'd8) begin
                            if (state == i2c_pkg::S_WR_BYTE) begin
                                sda_pull_low <= 1'b1;
                                state        <= i2c_pkg::S_WR_ACK;
                            end else if (shift[7:1] == SLAVE_ADDR) begin
                                rw           <= shift[0];
                                sda_pull_low <= 1'b1;
                                state        <= i2c_pkg::S_ADDR_ACK;
                            end else begin
                                state <= i2c_pkg::S_IDLE;
                            end
                        end
                    end
                    i2c_pkg::S_ADDR_ACK, i2c_pkg::S_WR_ACK: begin
                        if (scl_fall) begin
                            bit_cnt <= 4'd0;
                            if (load_rd) begin
                                sda_pull_low <= ~rd_data[7];
                                state        <= i2c_pkg::S_RD_BYTE;
                            end else begin
                                sda_pull_low <= 1'b0;
                                state        <= i2c_pkg::S_WR_BYTE;
                            end
                        end
                    end
                    i2c_pkg::S_RD_BYTE: begin
                        if (scl_rise) begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end else if (scl_fall) begin
                            if (bit_cnt == 4'd8) begin
                                sda_pull_low <= 1'b0;
                                state        <= i2c_pkg::S_RD_ACK;
                            end else begin
                                sda_pull_low <= ~shift[6];
                            end
                        end
                    end
                    i2c_pkg::S_RD_ACK: begin
                        if (scl_rise) begin
                            rd_acked    <= ~sda_s;
                            reg_rd_next <= ~sda_s;
                        end else if (scl_fall) begin
                            bit_cnt <= 4'd0;
                            if (load_rd) begin
                                sda_pull_low <= ~rd_data[7];
                                state        <= i2c_pkg::S_RD_BYTE;
                            end else begin
                                // A NACK ends the read, the master sends STOP next
                                state <= i2c_pkg::S_IDLE;
                            end
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (scl_rise && (state == i2c_pkg::S_ADDR || state == i2c_pkg::S_WR_BYTE)) begin
            shift <= {shift[6:0], sda_s};
        end else if (load_rd) begin
            shift <= rd_data;
        end else if (scl_fall && state == i2c_pkg::S_RD_BYTE) begin
            shift <= {shift[6:0], 1'b0};
        end
        if (scl_rise && state == i2c_pkg::S_WR_BYTE && bit_cnt == 4'd7) begin
            wr_data <= {shift[6:0], sda_s};
        end
    end

    a_idle_releases_sda: assert property (
        @(posedge clk) disable iff (reset)
        (state == i2c_pkg::S_IDLE) |-> !sda_pull_low
    );

endmodule

/* i2c_master.sv */
`timescale 1ns/1ps

module i2c_master #(
    parameter int CLK_DIV = 4
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  logic           stop,
    input  logic           i2c_en,
    input  i2c_pkg::byte_t tx_data,
    input  logic           sda_in,
    output logic           ready,
    output logic           tx_done,
    output logic           rx_done,
    output logic           nack,
    output i2c_pkg::byte_t rx_data,
    output logic           scl,
    output logic           sda_pull_low
);

    localparam int QW = $clog2(CLK_DIV + 1);
    localparam logic [QW-1:0] Q_LAST = QW'(CLK_DIV - 1);

    i2c_pkg::master_state_e state;
    i2c_pkg::i2c_cmd_e      cmd;
    i2c_pkg::i2c_cmd_e      cur_cmd;
    i2c_pkg::byte_t         shift;
    logic [QW-1:0]          qcnt;
    logic [1:0]             quarter;
    logic [2:0]             bit_cnt;
    logic                   tick;
    logic                   period_end;
    logic                   accept;
    logic                   samp;
    logic                   rw;
    logic                   is_read;
    logic                   ack_out;
    logic                   bus_open;
    logic                   scl_d;
    logic                   sda_d;

    always_comb begin
        case ({start, stop})
            2'b10:   cmd = i2c_pkg::CMD_START;
            2'b11:   cmd = i2c_pkg::CMD_READ_LAST;
            2'b01:   cmd = i2c_pkg::CMD_STOP;
            default: cmd = i2c_pkg::CMD_DATA;
        endcase
    end

    assign accept     = i2c_en && ready;
    assign tick       = (state != i2c_pkg::M_IDLE) && (qcnt == Q_LAST);
    assign period_end = tick && (quarter == 2'd3);

    // Bus levels per quarter. SCL is low in quarters 0 and 1 and high in 2 and 3,
    // SDA only moves from quarter 1 on so it never changes next to an SCL edge
    always_comb begin
        scl_d = ~bus_open;
        sda_d = sda_pull_low;
        case (state)
            i2c_pkg::M_IDLE: begin
                sda_d = 1'b0;
            end
            i2c_pkg::M_START: begin
                scl_d = 1'b1;
                sda_d = quarter[1];
            end
            i2c_pkg::M_SHIFT: begin
                scl_d = quarter[1];
                if (quarter != 2'd0) begin
                    sda_d = ~is_read & ~shift[7];
                end
            end
            i2c_pkg::M_ACK: begin
                scl_d = quarter[1];
                if (quarter != 2'd0) begin
                    sda_d = is_read & ~ack_out;
                end
            end
            i2c_pkg::M_STOP: begin
                scl_d = (quarter != 2'd0);
                sda_d = (quarter != 2'd3);
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            scl          <= 1'b1;
            sda_pull_low <= 1'b0;
        end else begin
            scl          <= scl_d;
            sda_pull_low <= sda_d;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= i2c_pkg::M_IDLE;
            cur_cmd  <= i2c_pkg::CMD_STOP;
            ready    <= 1'b1;
            tx_done  <= 1'b0;
            rx_done  <= 1'b0;
            nack     <= 1'b0;
            bus_open <= 1'b0;
            qcnt     <= '0;
            quarter  <= 2'd0;
            bit_cnt  <= 3'd0;
            rw       <= 1'b0;
            is_read  <= 1'b0;
            ack_out  <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            rx_done <= 1'b0;

            if (state == i2c_pkg::M_IDLE || state == i2c_pkg::M_DONE) begin
                qcnt    <= '0;
                quarter <= 2'd0;
            end else if (tick) begin
                qcnt    <= '0;
                quarter <= quarter + 2'd1;
            end else begin
                qcnt <= qcnt + 1'b1;
            end

            case (state)
                i2c_pkg::M_IDLE: begin
                    if (accept) begin
                        ready   <= 1'b0;
                        cur_cmd <= cmd;
                        bit_cnt <= 3'd7;
                        // A plain data command follows the R/W bit of the last address
                        is_read <= (cmd == i2c_pkg::CMD_READ_LAST) ||
                                   (cmd == i2c_pkg::CMD_DATA && rw);
                        ack_out <= (cmd == i2c_pkg::CMD_READ_LAST);
                        case (cmd)
                            i2c_pkg::CMD_START: begin
                                rw       <= tx_data[0];
                                bus_open <= 1'b1;
                                state    <= i2c_pkg::M_START;
                            end
                            i2c_pkg::CMD_STOP: begin
                                state <= i2c_pkg::M_STOP;
                            end
                            default: begin
                                state <= i2c_pkg::M_SHIFT;
                            end
                        endcase
                    end
                end
                i2c_pkg::M_START: begin
                    if (period_end) begin
                        state <= i2c_pkg::M_SHIFT;
                    end
                end
                i2c_pkg::M_SHIFT: begin
                    if (period_end) begin
                        if (bit_cnt == 3'd0) begin
                            state <= i2c_pkg::M_ACK;
                        end else begin
                            bit_cnt <= bit_cnt - 3'd1;
                        end
                    end
                end
                i2c_pkg::M_ACK: begin
                    if (period_end) begin
                        state <= i2c_pkg::M_DONE;
                    end
                end
                i2c_pkg::M_STOP: begin
                    if (period_end) begin
                        bus_open <= 1'b0;
                        state    <= i2c_pkg::M_DONE;
                    end
                end
                i2c_pkg::M_DONE: begin
                    ready <= 1'b1;
                    state <= i2c_pkg::M_IDLE;
                    if (cur_cmd != i2c_pkg::CMD_STOP) begin
                        if (is_read) begin
                            rx_done <= 1'b1;
                        end else begin
                            tx_done <= 1'b1;
                            nack    <= samp;
                        end
                    end
                end
                default: begin
                    state <= i2c_pkg::M_IDLE;
                end
            endcase
        end
    end

    // SDA is sampled in the middle of the high phase, the shift happens once SCL is low again
    always_ff @(posedge clk) begin
        if (state == i2c_pkg::M_IDLE && accept) begin
            if (cmd == i2c_pkg::CMD_START || (cmd == i2c_pkg::CMD_DATA && !rw)) begin
                shift <= tx_data;
            end else begin
                shift <= 8'hFF;
            end
        end else if (state == i2c_pkg::M_SHIFT && period_end) begin
            shift <= {shift[6:0], samp};
        end
        if (tick && quarter == 2'd2) begin
            samp <= sda_in;
        end
        if (state == i2c_pkg::M_DONE && is_read) begin
            rx_data <= shift;
        end
    end

    a_ready_only_idle: assert property (
        @(posedge clk) disable iff (reset)
        (state != i2c_pkg::M_IDLE) |-> !ready
    );

    // A new command starts from the SCL level the previous one left behind
    a_scl_steady_on_accept: assert property (
        @(posedge clk) disable iff (reset)
        accept |=> $stable(scl)
    );

endmodule

/* i2c_pkg.sv */
package i2c_pkg;

    // Number of registers in the slave register file
    localparam int NUM_REGS = 4;

    typedef logic [7:0] byte_t;
    typedef logic [6:0] dev_addr_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_ptr_t;

    // Host command kinds, decoded from the start and stop inputs
    typedef enum logic [1:0] {
        CMD_START,
        CMD_DATA,
        CMD_READ_LAST,
        CMD_STOP
    } i2c_cmd_e;

    typedef enum logic [2:0] {
        M_IDLE,
        M_START,
        M_SHIFT,
        M_ACK,
        M_STOP,
        M_DONE
    } master_state_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR,
        S_ADDR_ACK,
        S_WR_BYTE,
        S_WR_ACK,
        S_RD_BYTE,
        S_RD_ACK
    } slave_state_e;

endpackage
